// File: source/atop_filter_params.svh
// ########################################
// Widths and limits of the ATOP filter
// ########################################

`ifndef ATOP_FILTER_PARAMS_SVH
`define ATOP_FILTER_PARAMS_SVH

// AXI ID width
`define ATOP_ID_W 4
// Address and data widths
`define ATOP_ADDR_W 32
`define ATOP_DATA_W 32
// Burst length field, beats minus one
`define ATOP_LEN_W 8
// Width of the AW atop field
`define ATOP_ATOP_W 6
// Downstream AWs allowed without a finished W burst
`define ATOP_MAX_WRITE_TXNS 4

`endif

// File: source/atop_filter_pkg.sv
// ########################################
// Channel field types and AXI encodings
// ########################################

`default_nettype none

`include "atop_filter_params.svh"

package atop_filter_pkg;

  typedef logic [`ATOP_ID_W-1:0]     id_t;
  typedef logic [`ATOP_ADDR_W-1:0]   addr_t;
  typedef logic [`ATOP_DATA_W-1:0]   data_t;
  typedef logic [`ATOP_DATA_W/8-1:0] strb_t;
  typedef logic [`ATOP_LEN_W-1:0]    len_t;
  // Bits 5:4 hold the kind, bit 5 also requests an R response
  typedef logic [`ATOP_ATOP_W-1:0]   atop_t;

  typedef enum logic [1:0] {NONE = 2'b00, STORE = 2'b01, LOAD = 2'b10, SWAP_CMP = 2'b11} atop_kind_e;

  typedef enum logic [1:0] {OKAY = 2'b00, EXOKAY = 2'b01, SLVERR = 2'b10, DECERR = 2'b11} resp_e;

endpackage

`default_nettype wire

// File: source/write_burst_tracker.sv
// ########################################
// Downstream write burst tracker
// Counts AWs against finished W bursts
// ########################################

`default_nettype none

`include "atop_filter_params.svh"

module write_burst_tracker (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic aw_fire_i,
  input  logic w_last_fire_i,
  output logic aw_pending_o,
  output logic w_ahead_o,
  output logic aw_room_o
);

  // Two bits at least so that minus one is distinct from the limit
  localparam int unsigned CNT_W =
      (`ATOP_MAX_WRITE_TXNS == 1) ? 2 : $clog2(`ATOP_MAX_WRITE_TXNS + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`ATOP_MAX_WRITE_TXNS);

  logic [CNT_W-1:0] cnt_d, cnt_q;
  logic             underflow_d, underflow_q;

  always_comb begin
    cnt_d       = cnt_q;
    underflow_d = underflow_q;
    if (aw_fire_i) begin
      cnt_d = cnt_d + CNT_W'(1);
    end
    if (w_last_fire_i) begin
      cnt_d = cnt_d - CNT_W'(1);
    end
    // Wrap below zero marks a W burst ahead of its AW
    if (underflow_q && (cnt_d == '0)) begin
      underflow_d = 1'b0;
    end else if ((cnt_q == '0) && (&cnt_d)) begin
      underflow_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q       <= '0;
      underflow_q <= 1'b0;
    end else begin
      cnt_q       <= cnt_d;
      underflow_q <= underflow_d;
    end
  end

  // AWs downstream still missing their W bursts
  assign aw_pending_o = !underflow_q && (cnt_q != '0);
  // Count sits at minus one
  assign w_ahead_o    = underflow_q && (&cnt_q);
  assign aw_room_o    = w_ahead_o || (!underflow_q && (cnt_q < CNT_MAX));

endmodule

`default_nettype wire

// File: source/write_ctrl.sv
// ########################################
// Write channel FSM of the ATOP filter
// Gates AW and W, swallows atomic bursts
// and injects the SLVERR B response
// ########################################

`default_nettype none

module write_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   s_aw_valid_i,
  input  atop_filter_pkg::id_t   s_aw_id_i,
  input  atop_filter_pkg::len_t  s_aw_len_i,
  input  atop_filter_pkg::atop_t s_aw_atop_i,
  input  logic                   s_w_valid_i,
  input  logic                   s_w_last_i,
  input  logic                   s_b_ready_i,
  input  logic                   m_aw_ready_i,
  input  logic                   m_w_ready_i,
  input  logic                   m_b_valid_i,
  input  atop_filter_pkg::id_t   m_b_id_i,
  input  atop_filter_pkg::resp_e m_b_resp_i,
  input  logic                   aw_pending_i,
  input  logic                   w_ahead_i,
  input  logic                   aw_room_i,
  input  logic                   r_busy_i,
  output logic                   s_aw_ready_o,
  output logic                   s_w_ready_o,
  output logic                   s_b_valid_o,
  output atop_filter_pkg::id_t   s_b_id_o,
  output atop_filter_pkg::resp_e s_b_resp_o,
  output logic                   m_aw_valid_o,
  output logic                   m_w_valid_o,
  output logic                   m_b_ready_o,
  output logic                   cmd_push_o,
  output atop_filter_pkg::id_t   cmd_id_o,
  output atop_filter_pkg::len_t  cmd_len_o
);

  import atop_filter_pkg::*;

  typedef enum logic [2:0] {
    RESET, FEED, BLOCK_AW, ABSORB_W, HOLD_B, INJECT_B, WAIT_R
  } state_e;

  state_e state_d, state_q;
  state_e after_w_state;
  id_t    id_q;
  logic   id_load;
  logic   aw_atomic;
  logic   w_last_in;

  // Atomic when the kind bits are not NONE
  assign aw_atomic = s_aw_valid_i && (atop_kind_e'(s_aw_atop_i[5:4]) != NONE);
  assign w_last_in = s_w_valid_i && s_w_last_i;

  // A stalled downstream B goes out before the injected one
  assign after_w_state = (m_b_valid_i && !s_b_ready_i) ? HOLD_B : INJECT_B;

  // R command taken straight from the accepted AW
  assign cmd_push_o = id_load && s_aw_atop_i[5];
  assign cmd_id_o   = s_aw_id_i;
  assign cmd_len_o  = s_aw_len_i;

  always_comb begin
    // AW and W closed by default
    m_aw_valid_o = 1'b0;
    s_aw_ready_o = 1'b0;
    m_w_valid_o  = 1'b0;
    s_w_ready_o  = 1'b0;
    // B fed through by default
    m_b_ready_o  = s_b_ready_i;
    s_b_valid_o  = m_b_valid_i;
    s_b_id_o     = m_b_id_i;
    s_b_resp_o   = m_b_resp_i;
    id_load      = 1'b0;
    state_d      = state_q;

    unique case (state_q)
      RESET: begin
        state_d = FEED;
      end

      FEED: begin
        // AW passes while the outstanding limit allows
        if (aw_room_i) begin
          m_aw_valid_o = s_aw_valid_i;
          s_aw_ready_o = m_aw_ready_i;
        end
        // W passes for waiting AWs or alongside a plain AW
        if (aw_pending_i || (s_aw_valid_i && !aw_atomic && !w_ahead_i)) begin
          m_w_valid_o = s_w_valid_i;
          s_w_ready_o = m_w_ready_i;
        end
        if (aw_atomic) begin
          m_aw_valid_o = 1'b0;
          s_aw_ready_o = 1'b0;
          if (aw_pending_i) begin
            // Earlier W bursts drain first, AW stays put
            state_d = BLOCK_AW;
          end else begin
            s_aw_ready_o = 1'b1;
            id_load      = 1'b1;
            m_w_valid_o  = 1'b0;
            s_w_ready_o  = 1'b1;
            state_d      = w_last_in ? after_w_state : ABSORB_W;
          end
        end
      end

      BLOCK_AW: begin
        if (aw_pending_i) begin
          m_w_valid_o = s_w_valid_i;
          s_w_ready_o = m_w_ready_i;
        end else begin
          // Held atomic AW taken now, its W burst swallowed
          s_aw_ready_o = 1'b1;
          id_load      = 1'b1;
          s_w_ready_o  = 1'b1;
          state_d      = w_last_in ? after_w_state : ABSORB_W;
        end
      end

      ABSORB_W: begin
        s_w_ready_o = 1'b1;
        if (w_last_in) begin
          state_d = after_w_state;
        end
      end

      HOLD_B: begin
        if (m_b_valid_i && s_b_ready_i) begin
          state_d = INJECT_B;
        end
      end

      INJECT_B: begin
        // Downstream B stalled while the error goes out
        m_b_ready_o = 1'b0;
        s_b_valid_o = 1'b1;
        s_b_id_o    = id_q;
        s_b_resp_o  = SLVERR;
        if (s_b_ready_i) begin
          state_d = r_busy_i ? WAIT_R : FEED;
        end
      end

      WAIT_R: begin
        // Back to feed-through only once the R injector is free
        if (!r_busy_i) begin
          state_d = FEED;
        end
      end

      default: begin
        state_d = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // ID of the absorbed atomic AW
  always_ff @(posedge clk_i) begin
    if (id_load) begin
      id_q <= s_aw_id_i;
    end
  end

endmodule

`default_nettype wire

// File: source/read_inject.sv
// ########################################
// R response injector of the ATOP filter
// Command register, beat count, R mux
// ########################################

`default_nettype none

module read_inject (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cmd_push_i,
  input  atop_filter_pkg::id_t   cmd_id_i,
  input  atop_filter_pkg::len_t  cmd_len_i,
  input  logic                   m_r_valid_i,
  input  atop_filter_pkg::id_t   m_r_id_i,
  input  atop_filter_pkg::data_t m_r_data_i,
  input  atop_filter_pkg::resp_e m_r_resp_i,
  input  logic                   m_r_last_i,
  input  logic                   s_r_ready_i,
  output logic                   r_busy_o,
  output logic                   s_r_valid_o,
  output atop_filter_pkg::id_t   s_r_id_o,
  output atop_filter_pkg::data_t s_r_data_o,
  output atop_filter_pkg::resp_e s_r_resp_o,
  output logic                   s_r_last_o,
  output logic                   m_r_ready_o
);

  import atop_filter_pkg::*;

  typedef enum logic [1:0] {RESET, FEED, HOLD, INJECT} state_e;

  state_e state_d, state_q;
  logic   cmd_valid_d, cmd_valid_q;
  id_t    cmd_id_q;
  len_t   cmd_len_q;
  len_t   beats_d, beats_q;

  // Busy while a command sits in the register
  assign r_busy_o = cmd_valid_q;

  always_comb begin
    // R fed through by default
    s_r_valid_o = m_r_valid_i;
    s_r_id_o    = m_r_id_i;
    s_r_data_o  = m_r_data_i;
    s_r_resp_o  = m_r_resp_i;
    s_r_last_o  = m_r_last_i;
    m_r_ready_o = s_r_ready_i;
    cmd_valid_d = cmd_valid_q || cmd_push_i;
    beats_d     = beats_q;
    state_d     = state_q;

    unique case (state_q)
      RESET: begin
        state_d = FEED;
      end

      FEED: begin
        // A stalled downstream beat must finish before injection
        if (m_r_valid_i && !s_r_ready_i) begin
          state_d = HOLD;
        end else if (cmd_valid_q) begin
          beats_d = cmd_len_q;
          state_d = INJECT;
        end
      end

      HOLD: begin
        if (m_r_valid_i && s_r_ready_i) begin
          state_d = FEED;
        end
      end

      INJECT: begin
        m_r_ready_o = 1'b0;
        s_r_valid_o = 1'b1;
        s_r_id_o    = cmd_id_q;
        s_r_data_o  = '0;
        s_r_resp_o  = SLVERR;
        s_r_last_o  = (beats_q == '0);
        if (s_r_ready_i) begin
          if (beats_q == '0) begin
            // Last beat out, command released
            cmd_valid_d = 1'b0;
            state_d     = FEED;
          end else begin
            beats_d = beats_q - len_t'(1);
          end
        end
      end

      default: begin
        state_d = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= RESET;
      cmd_valid_q <= 1'b0;
      beats_q     <= '0;
    end else begin
      state_q     <= state_d;
      cmd_valid_q <= cmd_valid_d;
      beats_q     <= beats_d;
    end
  end

  // Command payload, written only while idle
  always_ff @(posedge clk_i) begin
    if (cmd_push_i) begin
      cmd_id_q  <= cmd_id_i;
      cmd_len_q <= cmd_len_i;
    end
  end

endmodule

`default_nettype wire

// File: source/atop_filter_top.sv
// ########################################
// ATOP filter top level
// Tracker, write FSM and R injector
// ########################################

`default_nettype none

module atop_filter_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Upstream port, facing the manager
  input  atop_filter_pkg::id_t   s_aw_id_i,
  input  atop_filter_pkg::addr_t s_aw_addr_i,
  input  atop_filter_pkg::len_t  s_aw_len_i,
  input  atop_filter_pkg::atop_t s_aw_atop_i,
  input  logic                   s_aw_valid_i,
  output logic                   s_aw_ready_o,
  input  atop_filter_pkg::data_t s_w_data_i,
  input  atop_filter_pkg::strb_t s_w_strb_i,
  input  logic                   s_w_last_i,
  input  logic                   s_w_valid_i,
  output logic                   s_w_ready_o,
  output atop_filter_pkg::id_t   s_b_id_o,
  output atop_filter_pkg::resp_e s_b_resp_o,
  output logic                   s_b_valid_o,
  input  logic                   s_b_ready_i,
  input  atop_filter_pkg::id_t   s_ar_id_i,
  input  atop_filter_pkg::addr_t s_ar_addr_i,
  input  atop_filter_pkg::len_t  s_ar_len_i,
  input  logic                   s_ar_valid_i,
  output logic                   s_ar_ready_o,
  output atop_filter_pkg::id_t   s_r_id_o,
  output atop_filter_pkg::data_t s_r_data_o,
  output atop_filter_pkg::resp_e s_r_resp_o,
  output logic                   s_r_last_o,
  output logic                   s_r_valid_o,
  input  logic                   s_r_ready_i,
  // Downstream port, facing the subordinate
  output atop_filter_pkg::id_t   m_aw_id_o,
  output atop_filter_pkg::addr_t m_aw_addr_o,
  output atop_filter_pkg::len_t  m_aw_len_o,
  output atop_filter_pkg::atop_t m_aw_atop_o,
  output logic                   m_aw_valid_o,
  input  logic                   m_aw_ready_i,
  output atop_filter_pkg::data_t m_w_data_o,
  output atop_filter_pkg::strb_t m_w_strb_o,
  output logic                   m_w_last_o,
  output logic                   m_w_valid_o,
  input  logic                   m_w_ready_i,
  input  atop_filter_pkg::id_t   m_b_id_i,
  input  atop_filter_pkg::resp_e m_b_resp_i,
  input  logic                   m_b_valid_i,
  output logic                   m_b_ready_o,
  output atop_filter_pkg::id_t   m_ar_id_o,
  output atop_filter_pkg::addr_t m_ar_addr_o,
  output atop_filter_pkg::len_t  m_ar_len_o,
  output logic                   m_ar_valid_o,
  input  logic                   m_ar_ready_i,
  input  atop_filter_pkg::id_t   m_r_id_i,
  input  atop_filter_pkg::data_t m_r_data_i,
  input  atop_filter_pkg::resp_e m_r_resp_i,
  input  logic                   m_r_last_i,
  input  logic                   m_r_valid_i,
  output logic                   m_r_ready_o
);

  import atop_filter_pkg::*;

  logic aw_pending;
  logic w_ahead;
  logic aw_room;
  logic aw_fire;
  logic w_last_fire;
  logic r_busy;
  logic cmd_push;
  id_t  cmd_id;
  len_t cmd_len;

  // AW fields pass unchanged, atop never reaches downstream
  assign m_aw_id_o   = s_aw_id_i;
  assign m_aw_addr_o = s_aw_addr_i;
  assign m_aw_len_o  = s_aw_len_i;
  assign m_aw_atop_o = '0;
  assign m_w_data_o  = s_w_data_i;
  assign m_w_strb_o  = s_w_strb_i;
  assign m_w_last_o  = s_w_last_i;

  // Reads are untouched apart from the R mux
  assign m_ar_id_o    = s_ar_id_i;
  assign m_ar_addr_o  = s_ar_addr_i;
  assign m_ar_len_o   = s_ar_len_i;
  assign m_ar_valid_o = s_ar_valid_i;
  assign s_ar_ready_o = m_ar_ready_i;

  // Downstream handshakes seen by the tracker
  assign aw_fire     = m_aw_valid_o && m_aw_ready_i;
  assign w_last_fire = m_w_valid_o && m_w_ready_i && s_w_last_i;

  write_burst_tracker i_write_burst_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_fire_i     (aw_fire),
    .w_last_fire_i (w_last_fire),
    .aw_pending_o  (aw_pending),
    .w_ahead_o     (w_ahead),
    .aw_room_o     (aw_room)
  );

  write_ctrl i_write_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .s_aw_valid_i (s_aw_valid_i),
    .s_aw_id_i    (s_aw_id_i),
    .s_aw_len_i   (s_aw_len_i),
    .s_aw_atop_i  (s_aw_atop_i),
    .s_w_valid_i  (s_w_valid_i),
    .s_w_last_i   (s_w_last_i),
    .s_b_ready_i  (s_b_ready_i),
    .m_aw_ready_i (m_aw_ready_i),
    .m_w_ready_i  (m_w_ready_i),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_id_i     (m_b_id_i),
    .m_b_resp_i   (m_b_resp_i),
    .aw_pending_i (aw_pending),
    .w_ahead_i    (w_ahead),
    .aw_room_i    (aw_room),
    .r_busy_i     (r_busy),
    .s_aw_ready_o (s_aw_ready_o),
    .s_w_ready_o  (s_w_ready_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_id_o     (s_b_id_o),
    .s_b_resp_o   (s_b_resp_o),
    .m_aw_valid_o (m_aw_valid_o),
    .m_w_valid_o  (m_w_valid_o),
    .m_b_ready_o  (m_b_ready_o),
    .cmd_push_o   (cmd_push),
    .cmd_id_o     (cmd_id),
    .cmd_len_o    (cmd_len)
  );

  read_inject i_read_inject (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_push_i  (cmd_push),
    .cmd_id_i    (cmd_id),
    .cmd_len_i   (cmd_len),
    .m_r_valid_i (m_r_valid_i),
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_resp_i  (m_r_resp_i),
    .m_r_last_i  (m_r_last_i),
    .s_r_ready_i (s_r_ready_i),
    .r_busy_o    (r_busy),
    .s_r_valid_o (s_r_valid_o),
    .s_r_id_o    (s_r_id_o),
    .s_r_data_o  (s_r_data_o),
    .s_r_resp_o  (s_r_resp_o),
    .s_r_last_o  (s_r_last_o),
    .m_r_ready_o (m_r_ready_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_atop_filter.sv
// ########################################
// Testbench of the ATOP filter
// Downstream responder model, LCG stimulus
// and assertion based checks
// ########################################

`default_nettype none

`include "atop_filter_params.svh"

module tb_atop_filter;

  import atop_filter_pkg::*;

  localparam int TMO = 500;

  logic clk_i, rst_ni;
  id_t s_aw_id_i, s_b_id_o, s_ar_id_i, s_r_id_o, m_aw_id_o, m_b_id_i, m_ar_id_o, m_r_id_i;
  addr_t s_aw_addr_i, s_ar_addr_i, m_aw_addr_o, m_ar_addr_o;
  len_t s_aw_len_i, s_ar_len_i, m_aw_len_o, m_ar_len_o;
  atop_t s_aw_atop_i, m_aw_atop_o;
  data_t s_w_data_i, s_r_data_o, m_w_data_o, m_r_data_i;
  strb_t s_w_strb_i, m_w_strb_o;
  resp_e s_b_resp_o, s_r_resp_o, m_b_resp_i, m_r_resp_i;
  logic s_aw_valid_i, s_aw_ready_o, s_w_last_i, s_w_valid_i, s_w_ready_o;
  logic s_b_valid_o, s_b_ready_i, s_ar_valid_i, s_ar_ready_o;
  logic s_r_last_o, s_r_valid_o, s_r_ready_i;
  logic m_aw_valid_o, m_aw_ready_i, m_w_last_o, m_w_valid_o, m_w_ready_i;
  logic m_b_valid_i, m_b_ready_o, m_ar_valid_o, m_ar_ready_i;
  logic m_r_last_i, m_r_valid_i, m_r_ready_o;

  logic [31:0] seed = 32'h28e8df7f;
  int   errors = 0;
  logic w_hold = 1'b0;
  // Downstream AWs minus finished downstream W bursts
  int   outstanding = 0;
  logic absorbing = 1'b0;
  // Responder model state
  id_t  aw_ids[$];
  id_t  b_ids[$];
  int   w_early = 0;
  id_t  ar_id_q[$];
  addr_t ar_addr_q[$];
  len_t ar_len_q[$];
  int   rd_beat = 0;
  // Upstream expectations
  id_t  exp_b_id[$];
  logic exp_b_err[$];
  id_t  exp_r_id;
  int   r_left = 0;
  addr_t up_addr_q[$];
  len_t up_len_q[$];
  id_t  up_id_q[$];
  int   up_beat = 0;

  atop_filter_top UUT (.*);

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("Fail at time %0t: %s", $time, msg);
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TEST FAILED");
    $finish;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Pass-through and isolation rules
  a_atop_zero: assert property (@(posedge clk_i) m_aw_atop_o == '0)
    else report_fail("downstream atop not zero");
  a_aw_fields: assert property (@(posedge clk_i) disable iff (!rst_ni) m_aw_valid_o |->
      (m_aw_id_o == s_aw_id_i && m_aw_addr_o == s_aw_addr_i && m_aw_len_o == s_aw_len_i
       && s_aw_atop_i[5:4] == 2'b00))
    else report_fail("downstream AW differs or is atomic");
  a_w_fields: assert property (@(posedge clk_i) disable iff (!rst_ni) m_w_valid_o |->
      (!absorbing && !(s_aw_valid_i && s_aw_ready_o && s_aw_atop_i[5:4] != 2'b00)
       && m_w_data_o == s_w_data_i && m_w_strb_o == s_w_strb_i
       && m_w_last_o == s_w_last_i))
    else report_fail("downstream W differs or belongs to an atomic burst");
  a_b_pass: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (s_b_valid_o && s_b_resp_o != SLVERR) |->
      (m_b_valid_i && s_b_id_o == m_b_id_i && s_b_resp_o == m_b_resp_i))
    else report_fail("upstream B differs from downstream B");
  a_ar_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_ar_valid_o == s_ar_valid_i && m_ar_id_o == s_ar_id_i
      && m_ar_addr_o == s_ar_addr_i && m_ar_len_o == s_ar_len_i
      && s_ar_ready_o == m_ar_ready_i)
    else report_fail("downstream AR differs");
  a_aw_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_aw_valid_o |-> outstanding < `ATOP_MAX_WRITE_TXNS)
    else report_fail("AW offered beyond the outstanding limit");
  // Injected responses hold until accepted
  a_b_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (s_b_valid_o && !s_b_ready_i && s_b_resp_o == SLVERR) |=>
      (s_b_valid_o && $stable(s_b_id_o) && $stable(s_b_resp_o)))
    else report_fail("injected B changed before ready");
  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (s_r_valid_o && !s_r_ready_i && s_r_resp_o == SLVERR) |=>
      (s_r_valid_o && $stable(s_r_id_o) && $stable(s_r_data_o) && $stable(s_r_last_o)
       && $stable(s_r_resp_o)))
    else report_fail("injected R changed before ready");

  // Downstream responder model sampling at the edge and driving after it
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (m_aw_valid_o && m_aw_ready_i) begin
        outstanding++;
        if (w_early > 0) begin
          w_early--;
          b_ids.push_back(m_aw_id_o);
        end else begin
          aw_ids.push_back(m_aw_id_o);
        end
      end
      if (m_w_valid_o && m_w_ready_i && m_w_last_o) begin
        outstanding--;
        if (aw_ids.size() > 0) begin
          b_ids.push_back(aw_ids.pop_front());
        end else begin
          w_early++;
        end
      end
      if (m_b_valid_i && m_b_ready_o) begin
        void'(b_ids.pop_front());
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        ar_id_q.push_back(m_ar_id_o);
        ar_addr_q.push_back(m_ar_addr_o);
        ar_len_q.push_back(m_ar_len_o);
      end
      if (m_r_valid_i && m_r_ready_o) begin
        if (m_r_last_i) begin
          void'(ar_id_q.pop_front());
          void'(ar_addr_q.pop_front());
          void'(ar_len_q.pop_front());
          rd_beat = 0;
        end else begin
          rd_beat++;
        end
      end
    end
    #1;
    seed = lcg_next();
    m_aw_ready_i = seed[20];
    m_w_ready_i  = seed[21] && !w_hold;
    m_ar_ready_i = seed[22];
    s_b_ready_i  = seed[23];
    s_r_ready_i  = seed[24];
    m_b_valid_i  = (b_ids.size() > 0);
    m_b_id_i     = (b_ids.size() > 0) ? b_ids[0] : '0;
    m_b_resp_i   = OKAY;
    m_r_valid_i  = (ar_id_q.size() > 0);
    m_r_resp_i   = OKAY;
    if (ar_id_q.size() > 0) begin
      m_r_id_i   = ar_id_q[0];
      m_r_data_i = ar_addr_q[0] + 32'(rd_beat);
      m_r_last_i = (rd_beat == int'(ar_len_q[0]));
    end else begin
      m_r_id_i   = '0;
      m_r_data_i = '0;
      m_r_last_i = 1'b0;
    end
  end

  // Upstream scoreboard
  always @(posedge clk_i) begin
    int idx;
    logic atomic_aw;
    logic last_w;
    if (rst_ni) begin
      atomic_aw = s_aw_valid_i && s_aw_ready_o && (s_aw_atop_i[5:4] != 2'b00);
      last_w    = s_w_valid_i && s_w_ready_o && s_w_last_i;
      if (s_aw_valid_i && s_aw_ready_o) begin
        exp_b_id.push_back(s_aw_id_i);
        exp_b_err.push_back(atomic_aw);
        if (atomic_aw && s_aw_atop_i[5]) begin
          exp_r_id = s_aw_id_i;
          r_left   = int'(s_aw_len_i) + 1;
        end
      end
      absorbing <= atomic_aw ? !last_w : (absorbing && !last_w);
      if (s_b_valid_o && s_b_ready_i) begin
        idx = -1;
        foreach (exp_b_id[i]) begin
          if (idx < 0 && exp_b_id[i] == s_b_id_o
              && exp_b_err[i] == (s_b_resp_o == SLVERR)) begin
            idx = i;
          end
        end
        assert (idx >= 0) else report_fail("unexpected upstream B");
        if (idx >= 0) begin
          exp_b_id.delete(idx);
          exp_b_err.delete(idx);
        end
      end
      if (s_ar_valid_i && s_ar_ready_o) begin
        up_id_q.push_back(s_ar_id_i);
        up_addr_q.push_back(s_ar_addr_i);
        up_len_q.push_back(s_ar_len_i);
      end
      if (s_r_valid_o && s_r_ready_i && s_r_resp_o == SLVERR) begin
        assert (r_left > 0 && s_r_id_o == exp_r_id && s_r_data_o == '0
                && s_r_last_o == (r_left == 1))
          else report_fail("wrong injected R beat");
        r_left--;
      end else if (s_r_valid_o && s_r_ready_i) begin
        assert (up_id_q.size() > 0 && s_r_id_o == up_id_q[0]
                && s_r_data_o == up_addr_q[0] + 32'(up_beat)
                && s_r_last_o == (up_beat == int'(up_len_q[0])))
          else report_fail("wrong upstream R beat");
        if (s_r_last_o && up_id_q.size() > 0) begin
          void'(up_id_q.pop_front());
          void'(up_addr_q.pop_front());
          void'(up_len_q.pop_front());
          up_beat = 0;
        end else begin
          up_beat++;
        end
      end
    end
  end

  task automatic send_aw(input id_t id, input addr_t addr, input len_t len, input atop_t atop);
    int t;
    t = 0;
    s_aw_id_i    = id;
    s_aw_addr_i  = addr;
    s_aw_len_i   = len;
    s_aw_atop_i  = atop;
    s_aw_valid_i = 1'b1;
    forever begin
      @(posedge clk_i);
      if (s_aw_ready_o) break;
      t++;
      if (t > TMO) timeout_abort("AW handshake");
    end
    #1 s_aw_valid_i = 1'b0;
  endtask

  task automatic send_w(input len_t len);
    int t;
    for (int b = 0; b <= int'(len); b++) begin
      t = 0;
      s_w_data_i  = lcg_next();
      s_w_strb_i  = strb_t'(b + 1);
      s_w_last_i  = (b == int'(len));
      s_w_valid_i = 1'b1;
      forever begin
        @(posedge clk_i);
        if (s_w_ready_o) break;
        t++;
        if (t > TMO) timeout_abort("W handshake");
      end
      #1 s_w_valid_i = 1'b0;
    end
  endtask

  task automatic send_ar(input id_t id, input addr_t addr, input len_t len);
    int t;
    t = 0;
    s_ar_id_i    = id;
    s_ar_addr_i  = addr;
    s_ar_len_i   = len;
    s_ar_valid_i = 1'b1;
    forever begin
      @(posedge clk_i);
      if (s_ar_ready_o) break;
      t++;
      if (t > TMO) timeout_abort("AR handshake");
    end
    #1 s_ar_valid_i = 1'b0;
  endtask

  task automatic write_txn(input id_t id, input len_t len, input atop_t atop);
    fork
      send_aw(id, lcg_next(), len, atop);
      send_w(len);
    join
  endtask

  // Waits until every upstream and downstream response has returned
  task automatic wait_idle();
    int t;
    t = 0;
    while (exp_b_id.size() > 0 || r_left > 0 || up_id_q.size() > 0 || b_ids.size() > 0) begin
      @(posedge clk_i);
      t++;
      if (t > TMO) timeout_abort("outstanding responses");
    end
    #1;
  endtask

  initial begin
    rst_ni = 1'b0;
    {s_aw_valid_i, s_w_valid_i, s_ar_valid_i, s_w_last_i} = '0;
    {s_b_ready_i, s_r_ready_i, m_aw_ready_i, m_w_ready_i, m_ar_ready_i} = '0;
    {m_b_valid_i, m_r_valid_i, m_r_last_i} = '0;
    s_aw_id_i   = '0;
    s_aw_addr_i = '0;
    s_aw_len_i  = '0;
    s_aw_atop_i = '0;
    s_w_data_i  = '0;
    s_w_strb_i  = '0;
    s_ar_id_i   = '0;
    s_ar_addr_i = '0;
    s_ar_len_i  = '0;
    m_b_id_i    = '0;
    m_b_resp_i  = OKAY;
    m_r_id_i    = '0;
    m_r_data_i  = '0;
    m_r_resp_i  = OKAY;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    // Plain writes and reads
    for (int i = 0; i < 6; i++) begin
      write_txn(id_t'(i), len_t'(lcg_next() % 4), 6'b000000);
    end
    for (int i = 0; i < 4; i++) begin
      send_ar(id_t'(i + 8), lcg_next(), len_t'(lcg_next() % 5));
    end
    wait_idle();
    // Atomic store followed by loads of several lengths
    write_txn(4'h3, 8'd3, 6'b010000);
    wait_idle();
    write_txn(4'h5, 8'd2, 6'b100000);
    wait_idle();
    write_txn(4'h6, 8'd0, 6'b110001);
    wait_idle();
    // Atomic load while a long read streams
    fork
      send_ar(4'h9, 32'h1000, 8'd7);
      write_txn(4'h7, 8'd1, 6'b100010);
    join
    wait_idle();
    // Outstanding limit with W held off downstream
    w_hold = 1'b1;
    fork
      for (int i = 0; i < 6; i++) send_aw(id_t'(i), lcg_next(), 8'd1, 6'b000000);
      for (int i = 0; i < 6; i++) send_w(8'd1);
      begin
        repeat (40) @(posedge clk_i);
        #1 w_hold = 1'b0;
      end
    join
    wait_idle();
    repeat (10) @(posedge clk_i);
    $display("Checks done: %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (200000) @(posedge clk_i);
    timeout_abort("end of the test sequence");
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+source
source/atop_filter_pkg.sv
source/write_burst_tracker.sv
source/write_ctrl.sv
source/read_inject.sv
source/atop_filter_top.sv
dv/tb_atop_filter.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ATOP filter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_atop_filter -Mdir obj_dir

./obj_dir/Vtb_atop_filter | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
